//--- mips_core.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_ctrl_if.sv
rtl/mips_decode.sv
rtl/mips_regfile.sv
rtl/mips_execute.sv
rtl/mips_fetch.sv
rtl/mips_core.sv
tb/mips_core_props.sv
tb/mips_core_tb.sv

//--- rtl/mips_core.sv
// single-cycle mips-i core top, zero-wait instruction and data ports
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_core (
   input  logic                     clk,
   input  logic                     rst_b,
   input  logic [`MIPS_XLEN-1:0]    inst,       // same-cycle fetch data
   output logic [`MIPS_WORD_AW-1:0] inst_addr,
   output logic [`MIPS_WORD_AW-1:0] mem_addr,
   output logic [`MIPS_XLEN-1:0]    mem_wdata,
   input  logic [`MIPS_XLEN-1:0]    mem_rdata,  // same-cycle load data
   output logic                     mem_we,
   output logic                     halted
);
   logic [`MIPS_XLEN-1:0] rs_data;
   logic [`MIPS_XLEN-1:0] rt_data;
   logic [`MIPS_XLEN-1:0] v0_data;
   logic [`MIPS_XLEN-1:0] wr_data;
   logic [`MIPS_XLEN-1:0] alu_out;
   logic [`MIPS_XLEN-1:0] pc;
   logic                  equal;

   mips_ctrl_if ctrl ();

   mips_decode u_decode (
      .inst (inst),
      .ctrl (ctrl)
   );

   mips_regfile u_regfile (
      .clk     (clk),
      .rst_b   (rst_b),
      .ctrl    (ctrl),
      .wr_data (wr_data),
      .halted  (halted),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .v0_data (v0_data)
   );

   mips_execute u_execute (
      .ctrl      (ctrl),
      .rs_data   (rs_data),
      .rt_data   (rt_data),
      .mem_rdata (mem_rdata),
      .alu_out   (alu_out),
      .wr_data   (wr_data),
      .equal     (equal)
   );

   mips_fetch u_fetch (
      .clk     (clk),
      .rst_b   (rst_b),
      .ctrl    (ctrl),
      .rs_data (rs_data),
      .v0_data (v0_data),
      .equal   (equal),
      .pc      (pc),
      .halted  (halted)
   );

   // word addresses, byte offset dropped
   assign inst_addr = pc[`MIPS_XLEN-1:2];
   assign mem_addr  = alu_out[`MIPS_XLEN-1:2];
   assign mem_wdata = rt_data;
   assign mem_we    = ctrl.mem_we & ~halted; // no stores once stopped
endmodule

//--- rtl/mips_ctrl_if.sv
// decoded control bundle and instruction fields, decoder to datapath
`timescale 1ns/10ps
`include "mips_params.svh"

interface mips_ctrl_if;
   logic                    reg_we;      // gpr write
   logic                    reg_dst_rd;  // dest is rd, else rt
   mips_pkg::alu_op_e       alu_op;
   logic                    alu_src_imm; // operand b from imm16
   logic                    imm_signed;  // sign vs zero extend
   mips_pkg::wb_sel_e       wb_sel;
   logic                    mem_we;      // sw
   logic                    is_beq;
   logic                    is_bne;
   logic                    is_j;
   logic                    is_jr;
   logic                    is_syscall;
   logic                    ri;          // reserved instruction

   logic [`MIPS_REG_AW-1:0] rs;
   logic [`MIPS_REG_AW-1:0] rt;
   logic [`MIPS_REG_AW-1:0] rd;
   logic [4:0]              shamt;
   logic [15:0]             imm16;
   logic [25:0]             target26;

   modport dec (output reg_we, reg_dst_rd, alu_op, alu_src_imm, imm_signed, wb_sel, mem_we,
                output is_beq, is_bne, is_j, is_jr, is_syscall, ri,
                output rs, rt, rd, shamt, imm16, target26);
   modport exe (input alu_op, alu_src_imm, imm_signed, wb_sel, shamt, imm16);
   modport rf  (input rs, rt, rd, reg_dst_rd, reg_we);
   modport fet (input is_beq, is_bne, is_j, is_jr, is_syscall, ri, imm16, target26);
endinterface

//--- rtl/mips_decode.sv
// instruction decoder, splits fields and generates datapath control
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_decode (
   input  logic [`MIPS_XLEN-1:0] inst,
   mips_ctrl_if.dec              ctrl
);
   mips_pkg::opcode_e opcode;
   mips_pkg::funct_e  funct;

   assign opcode = mips_pkg::opcode_e'(inst[31:26]);
   assign funct  = mips_pkg::funct_e'(inst[5:0]);

   // raw fields, no qualification here
   assign ctrl.rs       = inst[25:21];
   assign ctrl.rt       = inst[20:16];
   assign ctrl.rd       = inst[15:11];
   assign ctrl.shamt    = inst[10:6];
   assign ctrl.imm16    = inst[15:0];
   assign ctrl.target26 = inst[25:0];

   always_comb begin
      // safe defaults, nothing written
      ctrl.reg_we      = 1'b0;
      ctrl.reg_dst_rd  = 1'b0;
      ctrl.alu_op      = mips_pkg::alu_add;
      ctrl.alu_src_imm = 1'b0;
      ctrl.imm_signed  = 1'b1;
      ctrl.wb_sel      = mips_pkg::wb_alu;
      ctrl.mem_we      = 1'b0;
      ctrl.is_beq      = 1'b0;
      ctrl.is_bne      = 1'b0;
      ctrl.is_j        = 1'b0;
      ctrl.is_jr       = 1'b0;
      ctrl.is_syscall  = 1'b0;
      ctrl.ri          = 1'b0;
      case (opcode)
         mips_pkg::op_special: begin
            ctrl.reg_we     = 1'b1; // cleared below for jr, syscall, bad funct
            ctrl.reg_dst_rd = 1'b1;
            case (funct)
               mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
               mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
               mips_pkg::fn_sra:  ctrl.alu_op = mips_pkg::alu_sra;
               mips_pkg::fn_sllv: ctrl.alu_op = mips_pkg::alu_sllv;
               mips_pkg::fn_srlv: ctrl.alu_op = mips_pkg::alu_srlv;
               mips_pkg::fn_srav: ctrl.alu_op = mips_pkg::alu_srav;
               mips_pkg::fn_add, mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
               mips_pkg::fn_sub, mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
               mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
               mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
               mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
               mips_pkg::fn_nor:  ctrl.alu_op = mips_pkg::alu_nor;
               mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
               mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
               mips_pkg::fn_jr: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.is_jr  = 1'b1;
               end
               mips_pkg::fn_syscall: begin
                  ctrl.reg_we     = 1'b0;
                  ctrl.is_syscall = 1'b1; // halts only if $v0 is exit code
               end
               default: begin
                  ctrl.reg_we = 1'b0;
                  ctrl.ri     = 1'b1;
               end
            endcase
         end
         mips_pkg::op_j:   ctrl.is_j = 1'b1;
         mips_pkg::op_beq: ctrl.is_beq = 1'b1;
         mips_pkg::op_bne: ctrl.is_bne = 1'b1;
         mips_pkg::op_addi, mips_pkg::op_addiu: begin
            ctrl.reg_we      = 1'b1; // no overflow trap, same as addiu
            ctrl.alu_src_imm = 1'b1;
         end
         mips_pkg::op_slti, mips_pkg::op_sltiu: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1; // sltiu still sign extends
            ctrl.alu_op      = (opcode == mips_pkg::op_slti) ? mips_pkg::alu_slt
                                                             : mips_pkg::alu_sltu;
         end
         mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_signed  = 1'b0; // logic imms zero extend
            case (opcode)
               mips_pkg::op_andi: ctrl.alu_op = mips_pkg::alu_and;
               mips_pkg::op_ori:  ctrl.alu_op = mips_pkg::alu_or;
               default:           ctrl.alu_op = mips_pkg::alu_xor;
            endcase
         end
         mips_pkg::op_lui: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_op      = mips_pkg::alu_lui;
         end
         mips_pkg::op_lw: begin
            ctrl.reg_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1; // base + offset
            ctrl.wb_sel      = mips_pkg::wb_mem;
         end
         mips_pkg::op_sw: begin
            ctrl.mem_we      = 1'b1;
            ctrl.alu_src_imm = 1'b1;
         end
         default: ctrl.ri = 1'b1; // unknown opcode, writes stay off
      endcase
   end

endmodule

//--- rtl/mips_execute.sv
// execute stage: immediate extend, alu, branch compare, write-back mux
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_execute (
   mips_ctrl_if.exe              ctrl,
   input  logic [`MIPS_XLEN-1:0] rs_data,
   input  logic [`MIPS_XLEN-1:0] rt_data,
   input  logic [`MIPS_XLEN-1:0] mem_rdata,
   output logic [`MIPS_XLEN-1:0] alu_out,
   output logic [`MIPS_XLEN-1:0] wr_data,
   output logic                  equal
);
   logic [`MIPS_XLEN-1:0] imm_ext;
   logic [`MIPS_XLEN-1:0] op_b;
   logic [4:0]            var_sh;  // rs[4:0] for variable shifts

   assign imm_ext = ctrl.imm_signed ? {{16{ctrl.imm16[15]}}, ctrl.imm16}
                                    : {16'b0, ctrl.imm16};
   assign op_b    = ctrl.alu_src_imm ? imm_ext : rt_data;
   assign var_sh  = rs_data[4:0];

   always_comb begin
      case (ctrl.alu_op)
         mips_pkg::alu_add:  alu_out = rs_data + op_b;
         mips_pkg::alu_sub:  alu_out = rs_data - op_b;
         mips_pkg::alu_and:  alu_out = rs_data & op_b;
         mips_pkg::alu_or:   alu_out = rs_data | op_b;
         mips_pkg::alu_xor:  alu_out = rs_data ^ op_b;
         mips_pkg::alu_nor:  alu_out = ~(rs_data | op_b);
         mips_pkg::alu_slt:  alu_out = {{(`MIPS_XLEN-1){1'b0}}, $signed(rs_data) < $signed(op_b)};
         mips_pkg::alu_sltu: alu_out = {{(`MIPS_XLEN-1){1'b0}}, rs_data < op_b};
         // shifts always act on rt
         mips_pkg::alu_sll:  alu_out = rt_data << ctrl.shamt;
         mips_pkg::alu_srl:  alu_out = rt_data >> ctrl.shamt;
         mips_pkg::alu_sra:  alu_out = $signed(rt_data) >>> ctrl.shamt;
         mips_pkg::alu_sllv: alu_out = rt_data << var_sh;
         mips_pkg::alu_srlv: alu_out = rt_data >> var_sh;
         mips_pkg::alu_srav: alu_out = $signed(rt_data) >>> var_sh;
         mips_pkg::alu_lui:  alu_out = {ctrl.imm16, 16'b0};
         default:            alu_out = rs_data + op_b; // spare code
      endcase
   end

   assign wr_data = (ctrl.wb_sel == mips_pkg::wb_mem) ? mem_rdata : alu_out;
   assign equal   = (rs_data == rt_data); // beq/bne condition
endmodule

//--- rtl/mips_fetch.sv
// fetch unit: pc register, next-pc select and sticky halt
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_fetch (
   input  logic                  clk,
   input  logic                  rst_b,
   mips_ctrl_if.fet              ctrl,
   input  logic [`MIPS_XLEN-1:0] rs_data,
   input  logic [`MIPS_XLEN-1:0] v0_data,
   input  logic                  equal,
   output logic [`MIPS_XLEN-1:0] pc,
   output logic                  halted
);
   logic [`MIPS_XLEN-1:0] pc_plus4;
   logic [`MIPS_XLEN-1:0] br_target;
   logic [`MIPS_XLEN-1:0] j_target;
   logic [`MIPS_XLEN-1:0] pc_next;
   logic                  taken;
   logic                  halt_now;  // this instruction stops the core
   mips_pkg::pc_sel_e     pc_sel;

   assign pc_plus4  = pc + 32'd4;
   assign br_target = pc_plus4 + {{14{ctrl.imm16[15]}}, ctrl.imm16, 2'b00};
   assign j_target  = {pc[31:28], ctrl.target26, 2'b00}; // same 256MB region
   assign taken     = (ctrl.is_beq & equal) | (ctrl.is_bne & ~equal);

   always_comb begin
      if (ctrl.is_jr)
         pc_sel = mips_pkg::pc_reg;
      else if (ctrl.is_j)
         pc_sel = mips_pkg::pc_jump;
      else if (taken)
         pc_sel = mips_pkg::pc_branch;
      else
         pc_sel = mips_pkg::pc_seq;
   end

   always_comb begin
      case (pc_sel)
         mips_pkg::pc_branch: pc_next = br_target;
         mips_pkg::pc_jump:   pc_next = j_target;
         mips_pkg::pc_reg:    pc_next = rs_data;
         default:             pc_next = pc_plus4;
      endcase
   end

   assign halt_now = ctrl.ri | (ctrl.is_syscall & (v0_data == `MIPS_SYSCALL_EXIT));

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc     <= `MIPS_TEXT_START;
         halted <= 1'b0;
      end else begin
         if (halt_now)
            halted <= 1'b1; // sticky until reset
         if (!halt_now && !halted)
            pc <= pc_next;  // frozen on the halting instruction
      end
   end
endmodule

//--- rtl/mips_params.svh
// mips core parameters: widths, reset pc and syscall exit rules
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and address width
`define MIPS_XLEN 32

// register index width, 32 gprs
`define MIPS_REG_AW 5

// word address width seen on the memory ports
`define MIPS_WORD_AW 30

// pc after reset, start of the text segment
`define MIPS_TEXT_START 32'h00400000

// $v0 value that makes syscall stop the core
`define MIPS_SYSCALL_EXIT 32'd10

// $v0 sits in gpr 2
`define MIPS_REG_V0 2

`endif

//--- rtl/mips_pkg.sv
// mips core types: opcode, funct, alu operation and select encodings
package mips_pkg;

   // primary opcode, inst[31:26]
   typedef enum logic [5:0] {
      op_special = 6'h00, // r-type, see funct
      op_j       = 6'h02,
      op_beq     = 6'h04,
      op_bne     = 6'h05,
      op_addi    = 6'h08,
      op_addiu   = 6'h09,
      op_slti    = 6'h0a,
      op_sltiu   = 6'h0b,
      op_andi    = 6'h0c,
      op_ori     = 6'h0d,
      op_xori    = 6'h0e,
      op_lui     = 6'h0f,
      op_lw      = 6'h23,
      op_sw      = 6'h2b
   } opcode_e;

   // funct field of special, inst[5:0]
   typedef enum logic [5:0] {
      fn_sll     = 6'h00,
      fn_srl     = 6'h02,
      fn_sra     = 6'h03,
      fn_sllv    = 6'h04,
      fn_srlv    = 6'h06,
      fn_srav    = 6'h07,
      fn_jr      = 6'h08,
      fn_syscall = 6'h0c,
      fn_add     = 6'h20,
      fn_addu    = 6'h21,
      fn_sub     = 6'h22,
      fn_subu    = 6'h23,
      fn_and     = 6'h24,
      fn_or      = 6'h25,
      fn_xor     = 6'h26,
      fn_nor     = 6'h27,
      fn_slt     = 6'h2a,
      fn_sltu    = 6'h2b
   } funct_e;

   // alu operation, fifteen of sixteen codes used
   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor, alu_slt, alu_sltu,
      alu_sll, alu_srl, alu_sra, alu_sllv, alu_srlv, alu_srav, alu_lui
   } alu_op_e;

   typedef enum logic {wb_alu, wb_mem} wb_sel_e; // register write source

   typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_reg} pc_sel_e;

endpackage

//--- rtl/mips_regfile.sv
// general purpose register file, two async reads, one write, $v0 tap
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_regfile (
   input  logic                 clk,
   input  logic                 rst_b,
   mips_ctrl_if.rf              ctrl,
   input  logic [`MIPS_XLEN-1:0] wr_data,
   input  logic                 halted,
   output logic [`MIPS_XLEN-1:0] rs_data,
   output logic [`MIPS_XLEN-1:0] rt_data,
   output logic [`MIPS_XLEN-1:0] v0_data
);
   logic [`MIPS_XLEN-1:0]   regs [1 << `MIPS_REG_AW];
   logic [`MIPS_REG_AW-1:0] wr_idx;

   assign wr_idx = ctrl.reg_dst_rd ? ctrl.rd : ctrl.rt; // r-type vs i-type dest

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < (1 << `MIPS_REG_AW); i++) begin
            regs[i] <= '0;
         end
      end else if (ctrl.reg_we && !halted && (wr_idx != '0)) begin
         regs[wr_idx] <= wr_data; // r0 never written so reads 0
      end
   end

   assign rs_data = regs[ctrl.rs];
   assign rt_data = regs[ctrl.rt];
   assign v0_data = regs[`MIPS_REG_V0]; // syscall argument
endmodule

//--- run_sim.sh
#!/bin/sh
# build the mips core testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f mips_core.f \
   --top-module mips_core_tb \
   -Mdir obj_dir \
   -o mips_core_sim

./obj_dir/mips_core_sim | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

//--- tb/mips_core_props.sv
// mips core checker for halt, store gating and reset pc rules
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_core_props (
   input logic                     clk,
   input logic                     rst_b,
   input logic [`MIPS_WORD_AW-1:0] inst_addr,
   input logic                     mem_we,
   input logic                     halted
);
   localparam logic [`MIPS_XLEN-1:0] text_start = `MIPS_TEXT_START;

   logic first_cyc; // high from reset until the first edge

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b)
         first_cyc <= 1'b1;
      else
         first_cyc <= 1'b0;
   end

   // the halting instruction itself never stores either
   no_store_halted: assert property (@(posedge clk) disable iff (!rst_b)
                                     halted |-> !mem_we && !$past(mem_we))
      else $error("store enable high on or after the halting instruction");

   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else $error("halted dropped without reset");

   // pc frozen on the halting word
   addr_frozen: assert property (@(posedge clk) disable iff (!rst_b)
                                 halted |=> $stable(inst_addr))
      else $error("inst_addr moved while halted");

   reset_pc: assert property (@(posedge clk) disable iff (!rst_b)
                              first_cyc |-> inst_addr == text_start[31:2])
      else $error("inst_addr not at text start after reset");
endmodule

//--- tb/mips_core_tb.sv
// mips core testbench: memory models, encoders and directed program tests
`timescale 1ns/10ps
`include "mips_params.svh"

module mips_core_tb;
   localparam int period      = 100;
   localparam int cap         = 200;  // cycles allowed per program
   localparam int n_tests     = 5;
   localparam int watchdog_ns = n_tests * (cap + 10) * period + 20 * period;
   localparam int text_word   = `MIPS_TEXT_START >> 2;

   logic        clk;
   logic        rst_b;
   logic [31:0] inst;
   logic [29:0] inst_addr;
   logic [29:0] mem_addr;
   logic [31:0] mem_wdata;
   logic [31:0] mem_rdata;
   logic        mem_we;
   logic        halted;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic        dmem_clear;   // refill dmem with sentinels
   logic [31:0] exp_q [$];    // alu results, slot order
   string       name_q [$];
   int          errors;
   int          timeouts;
   int          seed;
   int          pc_w;         // next program word
   int          slot;         // next alu result word

   mips_core dut (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst      (inst),
      .inst_addr (inst_addr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata),
      .mem_we    (mem_we),
      .halted    (halted)
   );

   bind mips_core mips_core_props u_props (
      .clk       (clk),
      .rst_b     (rst_b),
      .inst_addr (inst_addr),
      .mem_we    (mem_we),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // zero-wait memories, low address bits only
   assign inst      = imem[inst_addr[7:0]];
   assign mem_rdata = dmem[mem_addr[7:0]];

   function automatic logic [31:0] sentinel(input int a);
      return 32'hc0de0000 + 32'(a);
   endfunction

   always_ff @(posedge clk) begin
      if (dmem_clear) begin
         for (int i = 0; i < 256; i++) begin
            dmem[i] <= sentinel(i);
         end
      end else if (mem_we) begin
         dmem[mem_addr[7:0]] <= mem_wdata;
      end
   end

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   function automatic logic [31:0] r_word(input mips_pkg::funct_e fn, input int rd,
                                          input int rs, input int rt, input int sh);
      return {mips_pkg::op_special, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
   endfunction

   function automatic logic [31:0] i_word(input mips_pkg::opcode_e op, input int rt,
                                          input int rs, input int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]}; // imm wraps to 16 bits
   endfunction

   function automatic logic [31:0] j_word(input int target);
      return {mips_pkg::op_j, target[25:0]};
   endfunction

   task automatic put_inst(input logic [31:0] w);
      imem[pc_w] = w;
      pc_w++;
   endtask

   task automatic load_const(input int rt, input logic [31:0] val);
      put_inst({mips_pkg::op_lui, 5'd0, rt[4:0], val[31:16]});
      put_inst({mips_pkg::op_ori, rt[4:0], rt[4:0], val[15:0]});
   endtask

   task automatic exit_program();
      put_inst(i_word(mips_pkg::op_ori, `MIPS_REG_V0, 0, int'(`MIPS_SYSCALL_EXIT)));
      put_inst(r_word(mips_pkg::fn_syscall, 0, 0, 0, 0));
   endtask

   // op into r10, then sw r10 to the next slot
   task automatic alu_case(input string what, input logic [31:0] w, input logic [31:0] val);
      put_inst(w);
      put_inst(i_word(mips_pkg::op_sw, 10, 0, slot * 4));
      exp_q.push_back(val);
      name_q.push_back(what);
      slot++;
   endtask

   task automatic begin_test();
      @(negedge clk);
      rst_b      = 1'b0;
      dmem_clear = 1'b1;
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0; // sll r0 = nop
      end
      pc_w = 0;
      slot = 0;
      exp_q.delete();
      name_q.delete();
   endtask

   task automatic run_program(input string name);
      int n;
      repeat (8) @(negedge clk);
      rst_b      = 1'b1;
      dmem_clear = 1'b0;
      n          = 0;
      while (!halted && n < cap) begin
         @(negedge clk);
         n++;
      end
      if (!halted) begin
         $display("timeout: program %s did not halt within %0d cycles", name, cap);
         timeouts++;
      end
   endtask

   task automatic check_word(input int idx, input logic [31:0] exp, input string what);
      if (dmem[idx] !== exp) begin
         $display("ERR %0t: %s dmem[%0d] = %h, expected %h", $time, what, idx, dmem[idx], exp);
         errors++;
      end
   endtask

   task automatic check_halt(input int idx, input string what);
      if (halted !== 1'b1) begin
         $display("ERR %0t: %s halted = %b, expected 1", $time, what, halted);
         errors++;
      end
      if (inst_addr !== 30'(text_word + idx)) begin
         $display("ERR %0t: %s inst_addr = %h, expected %h", $time, what, inst_addr,
                  30'(text_word + idx));
         errors++;
      end
   endtask

   task automatic alu_test();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] r;
      logic [31:0] sx;
      logic [31:0] zx;
      logic [15:0] k;
      int          sh;
      int          imm;
      begin_test();
      a   = next_rand();
      b   = next_rand();
      sh  = next_rand() & 32'h1f;
      r   = next_rand();
      k   = r[15:0];
      imm = int'({16'h0, k});
      sx  = {{16{k[15]}}, k};
      zx  = {16'h0, k};
      load_const(8, a);
      load_const(9, b);
      alu_case("add", r_word(mips_pkg::fn_add, 10, 8, 9, 0), a + b); // no trap, wraps
      alu_case("addu", r_word(mips_pkg::fn_addu, 10, 8, 9, 0), a + b);
      alu_case("sub", r_word(mips_pkg::fn_sub, 10, 8, 9, 0), a - b);
      alu_case("subu", r_word(mips_pkg::fn_subu, 10, 8, 9, 0), a - b);
      alu_case("and", r_word(mips_pkg::fn_and, 10, 8, 9, 0), a & b);
      alu_case("or", r_word(mips_pkg::fn_or, 10, 8, 9, 0), a | b);
      alu_case("xor", r_word(mips_pkg::fn_xor, 10, 8, 9, 0), a ^ b);
      alu_case("nor", r_word(mips_pkg::fn_nor, 10, 8, 9, 0), ~(a | b));
      alu_case("slt", r_word(mips_pkg::fn_slt, 10, 8, 9, 0), {31'b0, $signed(a) < $signed(b)});
      alu_case("sltu", r_word(mips_pkg::fn_sltu, 10, 8, 9, 0), {31'b0, a < b});
      // shamt shifts act on rt = a
      alu_case("sll", r_word(mips_pkg::fn_sll, 10, 0, 8, sh), a << sh);
      alu_case("srl", r_word(mips_pkg::fn_srl, 10, 0, 8, sh), a >> sh);
      alu_case("sra", r_word(mips_pkg::fn_sra, 10, 0, 8, sh), $unsigned($signed(a) >>> sh));
      alu_case("sllv", r_word(mips_pkg::fn_sllv, 10, 9, 8, 0), a << b[4:0]);
      alu_case("srlv", r_word(mips_pkg::fn_srlv, 10, 9, 8, 0), a >> b[4:0]);
      alu_case("srav", r_word(mips_pkg::fn_srav, 10, 9, 8, 0),
               $unsigned($signed(a) >>> b[4:0]));
      alu_case("addi", i_word(mips_pkg::op_addi, 10, 8, imm), a + sx);
      alu_case("addiu", i_word(mips_pkg::op_addiu, 10, 8, imm), a + sx);
      alu_case("andi", i_word(mips_pkg::op_andi, 10, 8, imm), a & zx); // zero extended
      alu_case("ori", i_word(mips_pkg::op_ori, 10, 8, imm), a | zx);
      alu_case("xori", i_word(mips_pkg::op_xori, 10, 8, imm), a ^ zx);
      alu_case("slti", i_word(mips_pkg::op_slti, 10, 8, imm),
               {31'b0, $signed(a) < $signed(sx)});
      alu_case("sltiu", i_word(mips_pkg::op_sltiu, 10, 8, imm), {31'b0, a < sx});
      alu_case("lui", i_word(mips_pkg::op_lui, 10, 0, imm), {k, 16'h0});
      exit_program();
      run_program("alu");
      for (int i = 0; i < exp_q.size(); i++) begin
         check_word(i, exp_q[i], name_q[i]);
      end
   endtask

   task automatic load_store_test();
      logic [31:0] vals [4];
      logic [31:0] sums [4];
      logic [31:0] r;
      logic [15:0] offs;
      begin_test();
      load_const(11, 32'h100); // base at word 64
      for (int k = 0; k < 4; k++) begin
         vals[k] = next_rand();
         load_const(8, vals[k]);
         put_inst(i_word(mips_pkg::op_sw, 8, 0, (40 + k) * 4));
      end
      for (int k = 0; k < 4; k++) begin
         r       = next_rand();
         offs    = r[15:0];
         sums[k] = vals[k] + {{16{offs[15]}}, offs};
         put_inst(i_word(mips_pkg::op_lw, 9, 11, (40 + k - 64) * 4)); // negative offset
         put_inst(i_word(mips_pkg::op_addiu, 9, 9, int'({16'h0, offs})));
         put_inst(i_word(mips_pkg::op_sw, 9, 11, (60 + k - 64) * 4));
      end
      exit_program();
      run_program("load_store");
      for (int k = 0; k < 4; k++) begin
         check_word(40 + k, vals[k], "stored word");
         check_word(60 + k, sums[k], "loaded and incremented word");
      end
   endtask

   task automatic branch_jump_test();
      logic [31:0] marker;
      int          l2;
      begin_test();
      marker = next_rand();
      load_const(12, marker);
      put_inst(i_word(mips_pkg::op_ori, 8, 0, 5));
      put_inst(i_word(mips_pkg::op_ori, 9, 0, 5));
      put_inst(i_word(mips_pkg::op_ori, 10, 0, 7));
      put_inst(i_word(mips_pkg::op_beq, 9, 8, 1));  // taken
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 70 * 4));
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 71 * 4));
      put_inst(i_word(mips_pkg::op_bne, 10, 8, 1)); // taken
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 72 * 4));
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 73 * 4));
      put_inst(i_word(mips_pkg::op_beq, 10, 8, 1)); // falls through
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 74 * 4));
      put_inst(i_word(mips_pkg::op_bne, 9, 8, 1));  // falls through
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 75 * 4));
      put_inst(j_word(text_word + pc_w + 2));       // over one store
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 76 * 4));
      l2 = pc_w + 4;                                // lui, ori, jr, skipped sw
      load_const(13, 32'((text_word + l2) * 4));
      put_inst(r_word(mips_pkg::fn_jr, 0, 13, 0, 0));
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 77 * 4));
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 78 * 4));
      exit_program();
      run_program("branch_jump");
      check_word(70, sentinel(70), "beq taken skip");
      check_word(71, marker, "beq taken target");
      check_word(72, sentinel(72), "bne taken skip");
      check_word(73, marker, "bne taken target");
      check_word(74, marker, "beq not taken");
      check_word(75, marker, "bne not taken");
      check_word(76, sentinel(76), "j skip");
      check_word(77, sentinel(77), "jr skip");
      check_word(78, marker, "jr target");
   endtask

   task automatic r0_syscall_test();
      logic [31:0] marker;
      int          idx;
      begin_test();
      marker = next_rand();
      put_inst(i_word(mips_pkg::op_ori, 0, 0, 'h55)); // all dropped, r0 stays 0
      put_inst(i_word(mips_pkg::op_addiu, 0, 0, 3));
      put_inst(i_word(mips_pkg::op_lui, 0, 0, 'h1234));
      put_inst(i_word(mips_pkg::op_sw, 0, 0, 80 * 4));
      put_inst(i_word(mips_pkg::op_ori, `MIPS_REG_V0, 0, 4)); // not the exit code
      put_inst(r_word(mips_pkg::fn_syscall, 0, 0, 0, 0));
      load_const(12, marker);
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 81 * 4));
      put_inst(i_word(mips_pkg::op_ori, `MIPS_REG_V0, 0, int'(`MIPS_SYSCALL_EXIT)));
      idx = pc_w;
      put_inst(r_word(mips_pkg::fn_syscall, 0, 0, 0, 0));
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 82 * 4)); // after the halt
      run_program("r0_syscall");
      check_word(80, 32'h0, "r0 readback");
      check_word(81, marker, "store after non-exit syscall");
      check_word(82, sentinel(82), "store after exit syscall");
      check_halt(idx, "exit syscall");
   endtask

   task automatic reserved_inst_test();
      logic [31:0] marker;
      int          idx;
      begin_test();
      marker = next_rand();
      load_const(12, marker);
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 90 * 4));
      idx = pc_w;
      put_inst({6'h3f, 26'h0}); // opcode 0x3f unassigned
      put_inst(i_word(mips_pkg::op_sw, 12, 0, 91 * 4));
      exit_program();
      run_program("reserved_inst");
      check_word(90, marker, "store before reserved op");
      check_word(91, sentinel(91), "store after reserved op");
      check_halt(idx, "reserved op");
   endtask

   initial begin
      #(watchdog_ns);
      $display("watchdog: run exceeded %0d ns without finishing", watchdog_ns);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      seed       = 31033;
      errors     = 0;
      timeouts   = 0;
      rst_b      = 1'b0;
      dmem_clear = 1'b1;
      pc_w       = 0;
      slot       = 0;
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;
      end
      alu_test();
      load_store_test();
      branch_jump_test();
      r0_syscall_test();
      reserved_inst_test();
      $display("summary: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end
endmodule
